//--- loadStoreUnit.f
+incdir+.
lsuPkg.sv
loadAligner.sv
storeMerger.sv
tagDataArray.sv
lineRefiller.sv
lsuController.sv
loadStoreUnit.sv
tbMemoryModel.sv
tbLoadStoreUnit.sv

//--- Makefile
TOP = tbLoadStoreUnit

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f loadStoreUnit.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tbLoadStoreUnit.sv
/*
 * Testbench for the load/store unit
 *   directed loads, stores, LR/SC and atomics, hit latency
 *   random command run against a shadow memory and cache model
 *   reference function, compare process and summary
 */

`timescale 1ns/1ps
`default_nettype none

module tbLoadStoreUnit
    import lsuPkg::*;
;
    localparam int TimeoutCycles = 100;
    localparam int RandomCount = 300;
    localparam logic [31:0] Seed = 32'h7e93_eb5e;

    logic clk;
    logic rst;
    logic enable;
    lsuRequest_t req;
    logic done;
    lsuResult_t result;
    memRequest_t mem;
    logic grant;
    line_t readLine;

    // Shadow memory and shadow cache state
    line_t shadowMem [256];
    logic cacheValid [16];
    tag_t cacheTag [16];
    logic cacheRes [16];

    string expNames [$];
    lsuResult_t expResults [$];
    int checks = 0;
    int errors = 0;
    int lastLatency;
    logic lastMemSeen;

    loadStoreUnit u_dut (
        .clk, .rst, .enable, .req, .done, .result, .mem, .grant, .readLine
    );

    tbMemoryModel u_mem (
        .clk, .rst, .mem, .grant, .readLine
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(string name, line_t expected, line_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    function automatic int sizeBytes(accessSize_t s);
        return (s == SizeByte) ? 1 : (s == SizeHalf) ? 2 : 4;
    endfunction

    // Zero-extended little-endian bytes of one line
    function automatic word_t readBytes(logic [7:0] lineNo, logic [3:0] off, int n);
        word_t w;
        w = '0;
        for (int b = 0; b < n; b++) begin
            if (int'(off) + b < 16) begin
                w[b*8 +: 8] = shadowMem[lineNo][(int'(off) + b)*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic void writeBytes(logic [7:0] lineNo, logic [3:0] off, word_t w, int n);
        for (int b = 0; b < n; b++) begin
            shadowMem[lineNo][(int'(off) + b)*8 +: 8] = w[b*8 +: 8];
        end
    endfunction

    function automatic word_t atomicRef(atomicOp_t op, word_t operand, word_t old);
        case (op)
            AtomicSwap: return operand;
            AtomicAdd:  return operand + old;
            AtomicXor:  return operand ^ old;
            AtomicAnd:  return operand & old;
            AtomicOr:   return operand | old;
            AtomicMin:  return ($signed(operand) < $signed(old)) ? operand : old;
            AtomicMax:  return ($signed(operand) > $signed(old)) ? operand : old;
            AtomicMinu: return (operand < old) ? operand : old;
            default:    return (operand > old) ? operand : old;
        endcase
    endfunction

    // Expected result value with shadow memory and reservation updates
    function automatic word_t refResult(lsuRequest_t r);
        word_t addr;
        word_t oldWord;
        word_t raw;
        word_t value;
        logic [7:0] lineNo;
        logic [3:0] idx;
        logic hit;
        addr = r.base + r.imm;
        lineNo = addr[11:4];
        idx = addr[7:4];
        hit = cacheValid[idx] && (cacheTag[idx] == addr[31:8]);
        oldWord = readBytes(lineNo, addr[3:0], 4);
        value = '0;
        // A StoreConditional miss never refills
        if (!hit && r.cmd != CmdStoreConditional) begin
            cacheValid[idx] = 1'b1;
            cacheTag[idx] = addr[31:8];
            cacheRes[idx] = 1'b0;
        end
        case (r.cmd)
            CmdLoad: begin
                raw = readBytes(lineNo, addr[3:0], sizeBytes(r.size));
                if (r.size == SizeByte && !r.isUnsigned) begin
                    value = {{24{raw[7]}}, raw[7:0]};
                end else if (r.size == SizeHalf && !r.isUnsigned) begin
                    value = {{16{raw[15]}}, raw[15:0]};
                end else begin
                    value = raw;
                end
            end
            CmdStore: begin
                writeBytes(lineNo, addr[3:0], r.storeData, sizeBytes(r.size));
                cacheRes[idx] = 1'b0;
            end
            CmdLoadReserved: begin
                cacheRes[idx] = 1'b1;
                value = oldWord;
            end
            CmdStoreConditional: begin
                if (hit && cacheRes[idx]) begin
                    writeBytes(lineNo, addr[3:0], r.storeData, 4);
                    cacheRes[idx] = 1'b0;
                end else begin
                    value = 32'd1;
                end
            end
            default: begin
                writeBytes(lineNo, addr[3:0], atomicRef(r.atomicOp, r.storeData, oldWord), 4);
                cacheRes[idx] = 1'b0;
                value = oldWord;
            end
        endcase
        return value;
    endfunction

    task automatic runCommand(string name, lsuRequest_t r);
        lsuResult_t exp;
        int cycles;
        logic memSeen;
        @(posedge clk);
        exp.addr = r.base + r.imm;
        exp.value = refResult(r);
        expNames.push_back(name);
        expResults.push_back(exp);
        req <= r;
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        cycles = 1;
        @(negedge clk);
        memSeen = mem.readReq | mem.writeReq;
        while (!done && cycles < TimeoutCycles) begin
            @(negedge clk);
            cycles++;
            memSeen = memSeen | mem.readReq | mem.writeReq;
        end
        if (!done) begin
            $display("Timeout: %s got no done pulse within %0d cycles", name, TimeoutCycles);
            errors++;
            finishRun();
        end else begin
            lastLatency = cycles;
            lastMemSeen = memSeen;
        end
    endtask

    task automatic doCmd(string name, lsuCmd_t c, accessSize_t sz, logic uns, atomicOp_t op,
                         word_t base, word_t imm, word_t data);
        lsuRequest_t r;
        r = '{cmd: c, size: sz, isUnsigned: uns, atomicOp: op,
              base: base, imm: imm, storeData: data};
        runCommand(name, r);
    endtask

    // Compare each done pulse with the oldest expected result
    always @(negedge clk) begin
        lsuResult_t exp;
        string name;
        if (done) begin
            if (expResults.size() == 0) begin
                errors++;
                $display("Done pulse with no command pending");
            end else begin
                exp = expResults.pop_front();
                name = expNames.pop_front();
                checkValue(name, line_t'(exp), line_t'(result));
                checkValue({name, " memory"}, shadowMem[exp.addr[11:4]],
                           u_mem.image[exp.addr[11:4]]);
            end
        end
    end

    initial begin
        lsuCmd_t cmd;
        accessSize_t sz;
        atomicOp_t op;
        word_t addr;
        word_t imm;
        void'($urandom(Seed));
        rst = 1'b1;
        enable = 1'b0;
        req = '0;
        for (int i = 0; i < 16; i++) begin
            cacheValid[i] = 1'b0;
            cacheRes[i] = 1'b0;
            cacheTag[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset done", '0, line_t'(done));
        checkValue("reset readReq", '0, line_t'(mem.readReq));
        checkValue("reset writeReq", '0, line_t'(mem.writeReq));
        for (int i = 0; i < 256; i++) begin
            shadowMem[i] = u_mem.image[i];
        end

        // Loads from the preset image
        doCmd("lb", CmdLoad, SizeByte, 1'b0, AtomicSwap, 32'h100, 32'h3, '0);
        checkValue("first load refill", line_t'(1), line_t'(lastMemSeen));
        doCmd("lbu", CmdLoad, SizeByte, 1'b1, AtomicSwap, 32'h100, 32'h3, '0);
        doCmd("lh", CmdLoad, SizeHalf, 1'b0, AtomicSwap, 32'h100, 32'h2, '0);
        doCmd("lhu", CmdLoad, SizeHalf, 1'b1, AtomicSwap, 32'h100, 32'h2, '0);
        doCmd("lw", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h100, 32'h8, '0);
        doCmd("lw negative imm", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h110, -32'sd4, '0);

        // Stores merged into words
        doCmd("sb", CmdStore, SizeByte, 1'b0, AtomicSwap, 32'h200, 32'h5, 32'h0000_00a7);
        doCmd("sh", CmdStore, SizeHalf, 1'b0, AtomicSwap, 32'h200, 32'ha, 32'h0000_beef);
        doCmd("sw", CmdStore, SizeWord, 1'b0, AtomicSwap, 32'h200, 32'hc, 32'h1234_5678);
        doCmd("lw after sb", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h200, 32'h4, '0);
        doCmd("lw after sh", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h200, 32'h8, '0);
        doCmd("lw after sw", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h200, 32'hc, '0);

        // LR/SC
        doCmd("lr", CmdLoadReserved, SizeWord, 1'b0, AtomicSwap, 32'h300, '0, '0);
        doCmd("sc reserved", CmdStoreConditional, SizeWord, 1'b0, AtomicSwap,
              32'h300, '0, 32'h0000_cafe);
        doCmd("sc no reservation", CmdStoreConditional, SizeWord, 1'b0, AtomicSwap,
              32'h300, '0, 32'h1111_1111);
        doCmd("lr second", CmdLoadReserved, SizeWord, 1'b0, AtomicSwap, 32'h340, '0, '0);
        doCmd("sw intervening", CmdStore, SizeWord, 1'b0, AtomicSwap, 32'h340, 32'h4, 32'h55);
        doCmd("sc after store", CmdStoreConditional, SizeWord, 1'b0, AtomicSwap,
              32'h340, '0, 32'h2222_2222);
        doCmd("sc miss", CmdStoreConditional, SizeWord, 1'b0, AtomicSwap, 32'h3c0, '0, 32'h33);

        for (int i = 0; i < 9; i++) begin
            op = atomicOp_t'(4'(i));
            doCmd($sformatf("amo %s", op.name()), CmdAtomicMemOp, SizeWord, 1'b0, op,
                  32'h400, word_t'(4 * (i % 4)),
                  (i % 2 == 0) ? 32'hffff_ff80 : 32'h0000_0123);
        end

        // Line 0x400 is cached by the atomics
        doCmd("load hit", CmdLoad, SizeWord, 1'b0, AtomicSwap, 32'h400, '0, '0);
        checkValue("load hit latency", line_t'(2), line_t'(lastLatency));
        checkValue("load hit memory idle", '0, line_t'(lastMemSeen));

        // Four tags per index inside 1 KB
        for (int i = 0; i < RandomCount; i++) begin
            cmd = lsuCmd_t'(3'($urandom_range(4, 0)));
            sz = accessSize_t'(2'($urandom_range(2, 0)));
            op = atomicOp_t'(4'($urandom_range(8, 0)));
            addr = word_t'($urandom_range(1023, 0));
            if (!(cmd inside {CmdLoad, CmdStore}) || sz == SizeWord) begin
                addr = addr & ~32'h3;
            end else if (sz == SizeHalf) begin
                addr = addr & ~32'h1;
            end
            imm = word_t'($urandom_range(64, 0)) - 32'd32;
            doCmd($sformatf("random %0d", i), cmd, sz, 1'($urandom_range(1, 0)), op,
                  addr - imm, imm, $urandom());
        end

        @(posedge clk);
        finishRun();
    end

endmodule

`default_nettype wire

//--- tbMemoryModel.sv
/*
 * Testbench line memory
 *   4 KB image with an address-based fill pattern
 *   grants line reads and writes after a random delay of 0 to 3 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tbMemoryModel
    import lsuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  memRequest_t mem,
    output logic        grant,
    output line_t       readLine
);
    localparam int Lines = 256;

    line_t image [Lines];
    logic busy;
    int unsigned delay;
    logic [7:0] lineNo;

    assign lineNo = mem.addr[7:0];

    initial begin
        logic [11:0] a;
        for (int i = 0; i < Lines; i++) begin
            for (int b = 0; b < 16; b++) begin
                a = 12'(i * 16 + b);
                image[i][b*8 +: 8] = 8'(a * 37) + 8'(a[11:8] * 91);
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            grant <= 1'b0;
            busy <= 1'b0;
            delay <= 0;
            readLine <= '0;
        end else if (grant) begin
            grant <= 1'b0;
            busy <= 1'b0;
        end else if (busy) begin
            if (delay == 0) begin
                // Read data and write take effect with the grant
                grant <= 1'b1;
                readLine <= image[lineNo];
                if (mem.writeReq) begin
                    image[lineNo] <= mem.writeLine;
                end
            end else begin
                delay <= delay - 1;
            end
        end else if (mem.readReq || mem.writeReq) begin
            busy <= 1'b1;
            delay <= $urandom_range(3, 0);
        end
    end

endmodule

`default_nettype wire

//--- loadStoreUnit.sv
/*
 * Data cache load/store unit top level
 *   controller, tag and data array, memory port sequencer,
 *   load aligner and store merger
 */

`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit
    import lsuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  lsuRequest_t req,
    output logic        done,
    output lsuResult_t  result,
    output memRequest_t mem,
    input  logic        grant,
    input  line_t       readLine
);
    index_t arrayIndex;
    logic tagWrite;
    tagEntry_t tagWriteValue;
    tagEntry_t tagRead;
    byteMask_t dataWriteMask;
    line_t dataWriteLine;
    line_t dataReadLine;

    word_t loadValue;
    line_t storeLine;
    byteMask_t storeMask;
    offset_t addrOffset;
    accessSize_t size;
    logic isUnsigned;
    word_t storeValue;

    logic refillStart;
    logic writeStart;
    lineAddr_t lineAddr;
    logic refillDone;
    index_t refillIndex;
    logic refillWrite;
    tag_t refillTag;
    line_t refillData;

    lsuController u_controller (
        .clk, .rst, .enable, .req, .done, .result,
        .arrayIndex, .tagWrite, .tagWriteValue, .tagRead,
        .dataWriteMask, .dataWriteLine, .dataReadLine,
        .loadValue, .storeLine, .storeMask,
        .refillStart, .writeStart, .lineAddr, .refillDone,
        .refillIndex, .refillWrite, .refillTag, .refillData,
        .addrOffset, .size, .isUnsigned, .storeValue
    );

    tagDataArray u_array (
        .clk, .rst,
        .index(arrayIndex),
        .tagWrite, .tagWriteValue, .tagRead,
        .dataWriteMask, .dataWriteLine, .dataReadLine
    );

    // Write-through sends the merged line built for the array
    lineRefiller u_refiller (
        .clk, .rst, .refillStart, .writeStart, .lineAddr,
        .writeLine(dataWriteLine),
        .mem, .grant, .readLine,
        .refillIndex, .refillWrite, .refillTag, .refillData, .refillDone
    );

    loadAligner u_loadAligner (
        .line(dataReadLine), .offset(addrOffset), .size, .isUnsigned, .value(loadValue)
    );

    storeMerger u_storeMerger (
        .line(storeLine), .mask(storeMask), .offset(addrOffset), .size, .value(storeValue)
    );

endmodule

`default_nettype wire

//--- lsuController.sv
/*
 * Load/store command controller
 *   command FSM with address generation and hit detection
 *   reservation handling for LR/SC
 *   atomic ALU
 *   array access arbitration against the refiller
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsuConsts.svh"

module lsuController
    import lsuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  lsuRequest_t req,
    output logic        done,
    output lsuResult_t  result,
    output index_t      arrayIndex,
    output logic        tagWrite,
    output tagEntry_t   tagWriteValue,
    input  tagEntry_t   tagRead,
    output byteMask_t   dataWriteMask,
    output line_t       dataWriteLine,
    input  line_t       dataReadLine,
    input  word_t       loadValue,
    input  line_t       storeLine,
    input  byteMask_t   storeMask,
    output logic        refillStart,
    output logic        writeStart,
    output lineAddr_t   lineAddr,
    input  logic        refillDone,
    input  index_t      refillIndex,
    input  logic        refillWrite,
    input  tag_t        refillTag,
    input  line_t       refillData,
    output offset_t     addrOffset,
    output accessSize_t size,
    output logic        isUnsigned,
    output word_t       storeValue
);
    localparam int IndexLsb = `LSU_OFFSET_WIDTH;
    localparam int TagLsb = `LSU_OFFSET_WIDTH + `LSU_INDEX_WIDTH;

    typedef enum logic [2:0] {
        StateIdle,
        StateLoad,
        StateStore,
        StateRefill,
        StateWriteThrough,
        StateReserve
    } state_t;

    state_t stateReg;
    state_t stateNext;
    lsuRequest_t reqReg;
    addr_t addrReg;
    addr_t addrNext;
    word_t oldWordReg;
    logic doneNext;
    word_t valueNext;
    logic hit;
    line_t mergedLine;

    function automatic word_t atomicAlu(atomicOp_t op, word_t regValue, word_t memValue);
        unique case (op)
            AtomicSwap: return regValue;
            AtomicAdd:  return regValue + memValue;
            AtomicXor:  return regValue ^ memValue;
            AtomicAnd:  return regValue & memValue;
            AtomicOr:   return regValue | memValue;
            AtomicMin:  return ($signed(regValue) < $signed(memValue)) ? regValue : memValue;
            AtomicMax:  return ($signed(regValue) > $signed(memValue)) ? regValue : memValue;
            AtomicMinu: return (regValue < memValue) ? regValue : memValue;
            AtomicMaxu: return (regValue > memValue) ? regValue : memValue;
            default:    return '0;
        endcase
    endfunction

    assign addrNext = req.base + req.imm;
    assign addrOffset = addrReg[IndexLsb-1:0];
    assign lineAddr = addrReg[`LSU_ADDR_WIDTH-1:IndexLsb];
    assign hit = tagRead.valid && (tagRead.tag == addrReg[`LSU_ADDR_WIDTH-1:TagLsb]);

    // Reservations and atomics always work on whole words
    assign size = (reqReg.cmd inside {CmdLoad, CmdStore}) ? reqReg.size : SizeWord;
    assign isUnsigned = reqReg.isUnsigned;
    assign storeValue = (reqReg.cmd == CmdAtomicMemOp)
                      ? atomicAlu(reqReg.atomicOp, reqReg.storeData, oldWordReg)
                      : reqReg.storeData;

    always_comb begin
        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            mergedLine[b*8 +: 8] = storeMask[b] ? storeLine[b*8 +: 8] : dataReadLine[b*8 +: 8];
        end
    end

    always_comb begin
        stateNext = stateReg;
        doneNext = 1'b0;
        valueNext = '0;
        refillStart = 1'b0;
        writeStart = 1'b0;
        arrayIndex = addrReg[TagLsb-1:IndexLsb];
        tagWrite = 1'b0;
        tagWriteValue = tagRead;
        dataWriteMask = '0;
        dataWriteLine = mergedLine;

        unique case (stateReg)
            StateIdle: begin
                // Array read starts with the fresh address
                arrayIndex = addrNext[TagLsb-1:IndexLsb];
                if (enable) begin
                    stateNext = (req.cmd == CmdStore) ? StateStore : StateLoad;
                end
            end
            StateLoad: begin
                if (!hit && reqReg.cmd == CmdStoreConditional) begin
                    doneNext = 1'b1;
                    valueNext = 32'd1;
                    stateNext = StateIdle;
                end else if (!hit) begin
                    refillStart = 1'b1;
                    stateNext = StateRefill;
                end else if (reqReg.cmd == CmdLoadReserved) begin
                    stateNext = StateReserve;
                end else if (reqReg.cmd == CmdAtomicMemOp) begin
                    stateNext = StateStore;
                end else if (reqReg.cmd == CmdStoreConditional) begin
                    if (tagRead.reserved) begin
                        stateNext = StateStore;
                    end else begin
                        doneNext = 1'b1;
                        valueNext = 32'd1;
                        stateNext = StateIdle;
                    end
                end else begin
                    doneNext = 1'b1;
                    valueNext = loadValue;
                    stateNext = StateIdle;
                end
            end
            StateStore: begin
                if (!hit) begin
                    refillStart = 1'b1;
                    stateNext = StateRefill;
                end else begin
                    // Any store drops the line's reservation
                    tagWrite = 1'b1;
                    tagWriteValue.reserved = 1'b0;
                    dataWriteMask = storeMask;
                    writeStart = 1'b1;
                    stateNext = StateWriteThrough;
                end
            end
            StateRefill: begin
                arrayIndex = refillIndex;
                tagWrite = refillWrite;
                tagWriteValue = '{valid: 1'b1, reserved: 1'b0, tag: refillTag};
                dataWriteMask = {`LSU_LINE_BYTES{refillWrite}};
                dataWriteLine = refillData;
                if (refillDone) begin
                    stateNext = (reqReg.cmd == CmdStore) ? StateStore : StateLoad;
                end
            end
            StateWriteThrough: begin
                if (refillDone) begin
                    doneNext = 1'b1;
                    valueNext = (reqReg.cmd == CmdAtomicMemOp) ? oldWordReg : '0;
                    stateNext = StateIdle;
                end
            end
            default: begin
                tagWrite = 1'b1;
                tagWriteValue.reserved = 1'b1;
                doneNext = 1'b1;
                valueNext = oldWordReg;
                stateNext = StateIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stateReg <= StateIdle;
            done <= 1'b0;
        end else begin
            stateReg <= stateNext;
            done <= doneNext;
        end
    end

    always_ff @(posedge clk) begin
        if (stateReg == StateIdle && enable) begin
            reqReg <= req;
            addrReg <= addrNext;
        end
        if (stateReg == StateLoad) begin
            oldWordReg <= loadValue;
        end
        if (doneNext) begin
            result.addr <= addrReg;
            result.value <= valueNext;
        end
    end

endmodule

`default_nettype wire

//--- lineRefiller.sv
/*
 * Memory port sequencer
 *   line refill: read request, array write with valid set
 *   write-through: sends the merged line and waits for grant
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsuConsts.svh"

module lineRefiller
    import lsuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        refillStart,
    input  logic        writeStart,
    input  lineAddr_t   lineAddr,
    input  line_t       writeLine,
    output memRequest_t mem,
    input  logic        grant,
    input  line_t       readLine,
    output index_t      refillIndex,
    output logic        refillWrite,
    output tag_t        refillTag,
    output line_t       refillData,
    output logic        refillDone
);
    typedef enum logic [1:0] {
        StateIdle,
        StateRequest,
        StateFinish
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            mem.readReq <= 1'b0;
            mem.writeReq <= 1'b0;
        end else begin
            unique case (state)
                StateIdle: begin
                    if (refillStart || writeStart) begin
                        mem.readReq <= refillStart;
                        mem.writeReq <= writeStart;
                        state <= StateRequest;
                    end
                end
                StateRequest: begin
                    // Request held until the memory grants it
                    if (grant) begin
                        mem.readReq <= 1'b0;
                        mem.writeReq <= 1'b0;
                        state <= StateFinish;
                    end
                end
                default: begin
                    state <= StateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && (refillStart || writeStart)) begin
            mem.addr <= lineAddr;
            mem.writeLine <= writeLine;
        end
    end

    // Refill data goes into the array in the grant cycle
    assign refillWrite = (state == StateRequest) && grant && mem.readReq;
    assign refillData = readLine;
    assign refillIndex = mem.addr[`LSU_INDEX_WIDTH-1:0];
    assign refillTag = mem.addr[$bits(lineAddr_t)-1:`LSU_INDEX_WIDTH];
    assign refillDone = (state == StateFinish);

endmodule

`default_nettype wire

//--- tagDataArray.sv
/*
 * Direct-mapped cache storage
 *   valid vector cleared by reset
 *   reserved and tag memory
 *   byte-writable data memory, registered read on both
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsuConsts.svh"

module tagDataArray
    import lsuPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  logic      tagWrite,
    input  tagEntry_t tagWriteValue,
    output tagEntry_t tagRead,
    input  byteMask_t dataWriteMask,
    input  line_t     dataWriteLine,
    output line_t     dataReadLine
);
    localparam int Lines = 1 << `LSU_INDEX_WIDTH;

    logic [Lines-1:0] validBits;
    logic readValid;

    // Reserved bit on top of the tag
    logic [`LSU_TAG_WIDTH:0] tagMem [Lines];
    logic [`LSU_TAG_WIDTH:0] readTagBits;

    line_t dataMem [Lines];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (tagWrite) begin
                validBits[index] <= tagWriteValue.valid;
            end
            readValid <= validBits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagWrite) begin
            tagMem[index] <= {tagWriteValue.reserved, tagWriteValue.tag};
        end
        readTagBits <= tagMem[index];

        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            if (dataWriteMask[b]) begin
                dataMem[index][b*8 +: 8] <= dataWriteLine[b*8 +: 8];
            end
        end
        dataReadLine <= dataMem[index];
    end

    assign tagRead = '{valid: readValid, reserved: readTagBits[`LSU_TAG_WIDTH],
                       tag: readTagBits[`LSU_TAG_WIDTH-1:0]};

endmodule

`default_nettype wire

//--- storeMerger.sv
/*
 * Store data placement
 *   replicates the store value across the line
 *   and builds the byte write mask for its lane
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsuConsts.svh"

module storeMerger
    import lsuPkg::*;
(
    output line_t       line,
    output byteMask_t   mask,
    input  offset_t     offset,
    input  accessSize_t size,
    input  word_t       value
);

    always_comb begin
        // Every lane carries the value, the mask picks the one written
        unique case (size)
            SizeByte: begin
                line = {`LSU_LINE_BYTES{value[7:0]}};
                mask = byteMask_t'(1'b1) << offset;
            end
            SizeHalf: begin
                line = {(`LSU_LINE_BYTES / 2){value[15:0]}};
                mask = byteMask_t'(2'b11) << offset;
            end
            default: begin
                line = {(`LSU_LINE_BYTES / 4){value}};
                mask = byteMask_t'(4'b1111) << offset;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- loadAligner.sv
/*
 * Load data aligner
 *   selects a byte, halfword or word from a cache line
 *   and sign or zero extends it to a full word
 */

`timescale 1ns/1ps
`default_nettype none

module loadAligner
    import lsuPkg::*;
(
    input  line_t       line,
    input  offset_t     offset,
    input  accessSize_t size,
    input  logic        isUnsigned,
    output word_t       value
);
    word_t shifted;

    always_comb begin
        // Byte offset to bit shift
        shifted = word_t'(line >> {offset, 3'b000});

        unique case (size)
            SizeByte: begin
                value = isUnsigned ? {24'h0, shifted[7:0]}
                                   : {{24{shifted[7]}}, shifted[7:0]};
            end
            SizeHalf: begin
                value = isUnsigned ? {16'h0, shifted[15:0]}
                                   : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: begin
                value = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- lsuPkg.sv
/*
 * Shared types of the load/store unit
 *   data word, cache line, byte mask and address fields
 *   command, access size and atomic operation enums
 *   request, result, memory request and tag entry structs
 */

`default_nettype none

`include "lsuConsts.svh"

package lsuPkg;

    typedef logic [`LSU_WORD_WIDTH-1:0] word_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LSU_LINE_WIDTH-1:0] line_t;
    typedef logic [`LSU_LINE_BYTES-1:0] byteMask_t;

    typedef logic [`LSU_TAG_WIDTH-1:0] tag_t;
    typedef logic [`LSU_INDEX_WIDTH-1:0] index_t;
    typedef logic [`LSU_OFFSET_WIDTH-1:0] offset_t;
    typedef logic [`LSU_ADDR_WIDTH-`LSU_OFFSET_WIDTH-1:0] lineAddr_t;

    typedef enum logic [2:0] {
        CmdLoad,
        CmdStore,
        CmdLoadReserved,
        CmdStoreConditional,
        CmdAtomicMemOp
    } lsuCmd_t;

    // Sign handling of loads is carried separately by isUnsigned
    typedef enum logic [1:0] {
        SizeByte,
        SizeHalf,
        SizeWord
    } accessSize_t;

    typedef enum logic [3:0] {
        AtomicSwap,
        AtomicAdd,
        AtomicXor,
        AtomicAnd,
        AtomicOr,
        AtomicMin,
        AtomicMax,
        AtomicMinu,
        AtomicMaxu
    } atomicOp_t;

    typedef struct packed {
        lsuCmd_t cmd;
        accessSize_t size;
        logic isUnsigned;
        atomicOp_t atomicOp;
        word_t base;
        word_t imm;
        word_t storeData;
    } lsuRequest_t;

    typedef struct packed {
        addr_t addr;
        word_t value;
    } lsuResult_t;

    typedef struct packed {
        logic readReq;
        logic writeReq;
        lineAddr_t addr;
        line_t writeLine;
    } memRequest_t;

    typedef struct packed {
        logic valid;
        logic reserved;
        tag_t tag;
    } tagEntry_t;

endpackage

`default_nettype wire

//--- lsuConsts.svh
/*
 * Geometry of the data cache load/store unit
 *   address width, line size in bytes, index width
 *   derived offset, tag and line widths
 */

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

`define LSU_ADDR_WIDTH 32

// 16 bytes per line, 16 lines
`define LSU_LINE_BYTES 16
`define LSU_INDEX_WIDTH 4

`define LSU_WORD_WIDTH 32
`define LSU_LINE_WIDTH (`LSU_LINE_BYTES * 8)

`define LSU_OFFSET_WIDTH $clog2(`LSU_LINE_BYTES)
`define LSU_TAG_WIDTH (`LSU_ADDR_WIDTH - `LSU_INDEX_WIDTH - `LSU_OFFSET_WIDTH)

`endif
